// File: Bender.yml
package:
  name: byte_word_bridge

sources:
  - logic/fifo_asym_pkg.sv
  - logic/ram_2p_asym.sv
  - logic/fifo_sync_asym.sv
  - logic/byte_word_bridge.sv
  - target: test
    files:
      - bench/fifo_asym_sva.sv
      - bench/tb_byte_word_bridge.sv

// File: bench/fifo_asym_sva.sv
`timescale 1ns/1ns

module fifo_asym_sva #(
   parameter int ADDR_W = 6
) (
   input logic            clk,
   input logic            rst,
   input logic            r_empty,
   input logic            w_full,
   input logic [ADDR_W:0] level,
   input logic            w_en_int,
   input logic            r_en_int
);

   localparam logic [ADDR_W:0] DEPTH = (ADDR_W+1)'(1) << ADDR_W;

   flags_exclusive: assert property (@(posedge clk) disable iff (rst)
      !(r_empty && w_full))
      else $error("r_empty and w_full are high together");

   level_bounded: assert property (@(posedge clk) disable iff (rst)
      level <= DEPTH)
      else $error("level is above the FIFO depth");

   // idle cycle keeps the level
   level_idle: assert property (@(posedge clk) disable iff (rst)
      (!w_en_int && !r_en_int) |=> $stable(level))
      else $error("level changed without an accepted read or write");

endmodule

bind fifo_sync_asym fifo_asym_sva #(.ADDR_W(ADDR_W)) u_sva (
   .clk      (clk),
   .rst      (rst),
   .r_empty  (r_empty),
   .w_full   (w_full),
   .level    (level),
   .w_en_int (w_en_int),
   .r_en_int (r_en_int)
);

// File: bench/tb_byte_word_bridge.sv
`timescale 1ns/1ns

module tb_byte_word_bridge;

   localparam int OFF = 0;
   localparam int ON = 1;
   localparam int RND = 2;
   localparam int FIXED = 0;
   localparam int LFSR = 1;

   typedef struct {
      int         w_mode;
      int         r_mode;
      int         d_mode;
      logic [7:0] d_val;
      int         count;
   } row_t;

   logic        clk;
   logic        rst;
   logic        w_en;
   logic [7:0]  w_data;
   logic        w_full;
   logic [6:0]  w_level;
   logic        r_en;
   logic [31:0] r_data;
   logic        r_empty;
   logic [6:0]  r_level;

   row_t        rows[$];
   logic [7:0]  model_q[$];
   logic [31:0] exp_rdata;
   logic [15:0] lfsr_state;
   int          cycles;
   int          limit;

   byte_word_bridge UUT (
      .clk     (clk),
      .rst     (rst),
      .w_en    (w_en),
      .w_data  (w_data),
      .w_full  (w_full),
      .w_level (w_level),
      .r_en    (r_en),
      .r_data  (r_data),
      .r_empty (r_empty),
      .r_level (r_level)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // run limit, counted in clock cycles
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (limit > 0 && cycles > limit) begin
         $display("timeout: the test table did not finish within %0d cycles", limit);
         $display("Done: errors found");
         $fatal(1);
      end
   end

   // 16-bit Fibonacci LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // one LFSR step per bit taken
   task automatic take_bits(input int n, output logic [7:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[6:0], lfsr_state[15]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   task automatic add_row(input int wm, input int rm, input int dm, input logic [7:0] dv,
                          input int n);
      row_t r;
      r.w_mode = wm;
      r.r_mode = rm;
      r.d_mode = dm;
      r.d_val = dv;
      r.count = n;
      rows.push_back(r);
   endtask

   task automatic report_error(input string msg);
      $display("%s", msg);
      $display("Done: errors found");
      $fatal(1);
   endtask

   // compare DUT outputs against the byte queue model
   task automatic check_outputs();
      int          n;
      logic        exp_empty;
      logic        exp_full;
      n = model_q.size();
      exp_empty = (n < 4);
      exp_full = (n >= 64);
      assert (r_empty === exp_empty) else
         report_error($sformatf("error: r_empty is %h, expected %h", r_empty, exp_empty));
      assert (w_full === exp_full) else
         report_error($sformatf("error: w_full is %h, expected %h", w_full, exp_full));
      assert (r_level === 7'(n / 4)) else
         report_error($sformatf("error: r_level is %h, expected %h", r_level, 7'(n / 4)));
      assert (w_level === 7'(n)) else
         report_error($sformatf("error: w_level is %h, expected %h", w_level, 7'(n)));
      assert (r_data === exp_rdata) else
         report_error($sformatf("error: r_data is %h, expected %h", r_data, exp_rdata));
   endtask

   initial begin
      logic [7:0] bits;
      logic       we;
      logic       re;
      logic       w_ok;
      logic       r_ok;
      logic [7:0] d;
      rst = 1'b1;
      w_en = 1'b0;
      r_en = 1'b0;
      w_data = '0;
      exp_rdata = '0;
      lfsr_state = 16'd22;
      cycles = 0;
      limit = 0;

      // packing order
      add_row(ON, OFF, FIXED, 8'h11, 1);
      add_row(ON, OFF, FIXED, 8'h22, 1);
      add_row(ON, OFF, FIXED, 8'h33, 1);
      add_row(ON, OFF, FIXED, 8'h44, 1);
      add_row(OFF, ON, FIXED, 8'h00, 1);
      add_row(OFF, OFF, FIXED, 8'h00, 2);
      // fill to full, one dropped write, then drain
      add_row(ON, OFF, LFSR, 8'h00, 64);
      add_row(ON, OFF, FIXED, 8'hee, 1);
      add_row(OFF, ON, FIXED, 8'h00, 16);
      // three bytes is still empty
      add_row(ON, OFF, LFSR, 8'h00, 3);
      add_row(OFF, ON, FIXED, 8'h00, 1);
      add_row(ON, OFF, LFSR, 8'h00, 1);
      add_row(OFF, ON, FIXED, 8'h00, 1);
      // write and read in the same cycle
      add_row(ON, OFF, LFSR, 8'h00, 8);
      add_row(ON, ON, LFSR, 8'h00, 2);
      add_row(OFF, ON, FIXED, 8'h00, 3);
      // random interleaving, then drain
      add_row(RND, RND, LFSR, 8'h00, 300);
      add_row(OFF, ON, FIXED, 8'h00, 20);

      foreach (rows[i]) begin
         limit = limit + rows[i].count;
      end
      limit = limit + 20;

      repeat (4) @(posedge clk);
      #2;
      rst = 1'b0;
      check_outputs();

      foreach (rows[i]) begin
         for (int k = 0; k < rows[i].count; k++) begin
            we = (rows[i].w_mode == ON);
            re = (rows[i].r_mode == ON);
            // random write about 3 in 4, random read about 1 in 8
            if (rows[i].w_mode == RND) begin
               take_bits(2, bits);
               we = (bits[1:0] != 2'b00);
            end
            if (rows[i].r_mode == RND) begin
               take_bits(3, bits);
               re = (bits[2:0] == 3'b000);
            end
            d = rows[i].d_val;
            if (rows[i].d_mode == LFSR) begin
               take_bits(8, d);
            end
            w_en = we;
            r_en = re;
            w_data = d;

            // acceptance from the model's own flags, both taken before the update
            w_ok = we && (model_q.size() < 64);
            r_ok = re && (model_q.size() >= 4);
            if (r_ok) begin
               for (int b = 0; b < 4; b++) begin
                  exp_rdata[b*8 +: 8] = model_q.pop_front();
               end
            end
            if (w_ok) begin
               model_q.push_back(d);
            end
            @(posedge clk);
            #2;
            check_outputs();
         end
      end

      w_en = 1'b0;
      r_en = 1'b0;
      $display("Done: no errors");
      $finish;
   end

endmodule

// File: filelist.f
logic/fifo_asym_pkg.sv
logic/ram_2p_asym.sv
logic/fifo_sync_asym.sv
logic/byte_word_bridge.sv
bench/fifo_asym_sva.sv
bench/tb_byte_word_bridge.sv

// File: logic/byte_word_bridge.sv
`timescale 1ns/1ns

// bytes in, 32-bit words out, first byte in the low bits
module byte_word_bridge #(
   // write port width, a power of two
   parameter int W_DATA_W = fifo_asym_pkg::DEF_W_DATA_W,
   // read port width, a power of two
   parameter int R_DATA_W = fifo_asym_pkg::DEF_R_DATA_W,
   // depth as log2 of narrow units
   parameter int ADDR_W = fifo_asym_pkg::DEF_ADDR_W
) (
   input  logic                clk,
   input  logic                rst,

   // byte side
   input  logic                w_en,
   input  logic [W_DATA_W-1:0] w_data,
   output logic                w_full,
   output logic [ADDR_W:0]     w_level,

   // word side
   input  logic                r_en,
   output logic [R_DATA_W-1:0] r_data,
   output logic                r_empty,
   output logic [ADDR_W:0]     r_level
);

   // excess writes past full are dropped inside the FIFO
   fifo_sync_asym #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) u_fifo (
      .clk     (clk),
      .rst     (rst),

      .w_en    (w_en),
      .w_data  (w_data),
      .w_full  (w_full),
      .w_level (w_level),

      .r_en    (r_en),
      .r_data  (r_data),
      .r_empty (r_empty),
      .r_level (r_level)
   );

endmodule

// File: logic/fifo_asym_pkg.sv
package fifo_asym_pkg;

   // default bridge shape: bytes in, 32-bit words out
   localparam int DEF_W_DATA_W = 8;
   localparam int DEF_R_DATA_W = 32;
   // depth in narrow units, 64 bytes
   localparam int DEF_ADDR_W = 6;

   // larger of the two port widths
   function automatic int max_w(input int a, input int b);
      return (a > b) ? a : b;
   endfunction

   // smaller of the two port widths, also the lane width
   function automatic int min_w(input int a, input int b);
      return (a < b) ? a : b;
   endfunction

   // log2 of wide/narrow ratio
   // widths are powers of two so the ratio is exact
   function automatic int ratio_log2(input int a, input int b);
      int r;
      int n;
      r = max_w(a, b) / min_w(a, b);
      n = 0;
      while (r > 1) begin
         r = r >> 1;
         n = n + 1;
      end
      return n;
   endfunction

endpackage

// File: logic/fifo_sync_asym.sv
`timescale 1ns/1ns

module fifo_sync_asym #(
   parameter int W_DATA_W = 8,
   parameter int R_DATA_W = 32,
   // depth is 2**ADDR_W narrow units
   parameter int ADDR_W = 6
) (
   input  logic                clk,
   input  logic                rst,

   // write side
   input  logic                w_en,
   input  logic [W_DATA_W-1:0] w_data,
   output logic                w_full,
   output logic [ADDR_W:0]     w_level,

   // read side
   input  logic                r_en,
   output logic [R_DATA_W-1:0] r_data,
   output logic                r_empty,
   output logic [ADDR_W:0]     r_level
);

   localparam int MAX_W = fifo_asym_pkg::max_w(W_DATA_W, R_DATA_W);
   localparam int MIN_W = fifo_asym_pkg::min_w(W_DATA_W, R_DATA_W);
   localparam int RL2 = fifo_asym_pkg::ratio_log2(W_DATA_W, R_DATA_W);

   // wide port uses fewer address bits
   localparam int W_ADDR_W = (W_DATA_W > MIN_W) ? ADDR_W - RL2 : ADDR_W;
   localparam int R_ADDR_W = (R_DATA_W > MIN_W) ? ADDR_W - RL2 : ADDR_W;

   // narrow units per port word, as a shift
   localparam int W_SHIFT = (W_DATA_W == MAX_W) ? RL2 : 0;
   localparam int R_SHIFT = (R_DATA_W == MAX_W) ? RL2 : 0;

   localparam logic [ADDR_W:0] W_INCR = (ADDR_W+1)'(1) << W_SHIFT;
   localparam logic [ADDR_W:0] R_INCR = (ADDR_W+1)'(1) << R_SHIFT;
   localparam logic [ADDR_W:0] DEPTH = (ADDR_W+1)'(1) << ADDR_W;

   logic                w_en_int;
   logic                r_en_int;
   logic [W_ADDR_W-1:0] w_addr;
   logic [R_ADDR_W-1:0] r_addr;

   // level in narrow units
   logic [ADDR_W:0]     level;
   logic [ADDR_W:0]     level_nxt;

   // only accepted transfers reach the memory
   assign w_en_int = w_en & ~w_full;
   assign r_en_int = r_en & ~r_empty;

   // write address, wraps at the end of the memory
   always_ff @(posedge clk) begin
      if (rst) begin
         w_addr <= '0;
      end else if (w_en_int) begin
         w_addr <= w_addr + 1'b1;
      end
   end

   // read address
   always_ff @(posedge clk) begin
      if (rst) begin
         r_addr <= '0;
      end else if (r_en_int) begin
         r_addr <= r_addr + 1'b1;
      end
   end

   // net change of both sides in one cycle
   // guards on the enables keep this inside 0..DEPTH
   always_comb begin
      level_nxt = level;
      if (w_en_int) begin
         level_nxt = level_nxt + W_INCR;
      end
      if (r_en_int) begin
         level_nxt = level_nxt - R_INCR;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         level <= '0;
      end else begin
         level <= level_nxt;
      end
   end

   // empty while less than one read word is stored
   assign r_empty = level < R_INCR;

   // full while a whole write word no longer fits
   assign w_full = level > (DEPTH - W_INCR);

   // levels in each port's own words, rounded down
   assign w_level = level >> W_SHIFT;
   assign r_level = level >> R_SHIFT;

   ram_2p_asym #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) u_ram (
      .clk    (clk),
      .rst    (rst),
      .w_en   (w_en_int),
      .w_addr (w_addr),
      .w_data (w_data),
      .r_en   (r_en_int),
      .r_addr (r_addr),
      .r_data (r_data)
   );

endmodule

// File: logic/ram_2p_asym.sv
`timescale 1ns/1ns

module ram_2p_asym #(
   parameter int W_DATA_W = 8,
   parameter int R_DATA_W = 32,
   parameter int ADDR_W = 6,
   // derived, not meant to be overridden
   parameter int W_ADDR_W = (W_DATA_W > R_DATA_W) ?
                            ADDR_W - fifo_asym_pkg::ratio_log2(W_DATA_W, R_DATA_W) : ADDR_W,
   parameter int R_ADDR_W = (R_DATA_W > W_DATA_W) ?
                            ADDR_W - fifo_asym_pkg::ratio_log2(W_DATA_W, R_DATA_W) : ADDR_W
) (
   input  logic                clk,
   input  logic                rst,

   // write port
   input  logic                w_en,
   input  logic [W_ADDR_W-1:0] w_addr,
   input  logic [W_DATA_W-1:0] w_data,

   // read port
   input  logic                r_en,
   input  logic [R_ADDR_W-1:0] r_addr,
   output logic [R_DATA_W-1:0] r_data
);

   // lane is the narrow width
   localparam int MIN_W = fifo_asym_pkg::min_w(W_DATA_W, R_DATA_W);
   localparam int MAX_W = fifo_asym_pkg::max_w(W_DATA_W, R_DATA_W);
   localparam int RL2 = fifo_asym_pkg::ratio_log2(W_DATA_W, R_DATA_W);

   // lanes per port word
   localparam int W_LANES = W_DATA_W / MIN_W;
   localparam int R_LANES = R_DATA_W / MIN_W;

   // the wide port's word address sits above the lane bits
   localparam int W_SHIFT = (W_DATA_W == MAX_W) ? RL2 : 0;
   localparam int R_SHIFT = (R_DATA_W == MAX_W) ? RL2 : 0;

   localparam int DEPTH = 1 << ADDR_W;

   logic [MIN_W-1:0] mem [0:DEPTH-1];

   // first lane of the addressed word, in narrow units
   logic [ADDR_W-1:0] w_base;
   logic [ADDR_W-1:0] r_base;

   assign w_base = ADDR_W'(w_addr) << W_SHIFT;
   assign r_base = ADDR_W'(r_addr) << R_SHIFT;

   // wide write spreads over consecutive lanes
   // lowest bits go to the lowest lane
   always_ff @(posedge clk) begin
      if (w_en) begin
         for (int i = 0; i < W_LANES; i++) begin
            mem[w_base + ADDR_W'(i)] <= w_data[i*MIN_W +: MIN_W];
         end
      end
   end

   // registered read, lanes gathered lowest first
   always_ff @(posedge clk) begin
      if (rst) begin
         r_data <= '0;
      end else if (r_en) begin
         for (int i = 0; i < R_LANES; i++) begin
            r_data[i*MIN_W +: MIN_W] <= mem[r_base + ADDR_W'(i)];
         end
      end
   end

endmodule
